// ==== beam_sequencer.sv ====
// beam sequencer FSM: walks the frame ram, drives the dac channels with per-point dwell, halt
`default_nettype none

module beam_sequencer import vector_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               go,
    input  display_word_u      rd_data,
    output logic [ADDR_W-1:0]  rd_addr,
    output logic [COORD_W-1:0] xch,
    output logic [COORD_W-1:0] ych,
    output logic               beam_on,
    output logic               dac_load,
    output logic               halt
);

    enum logic [2:0] {S_IDLE, S_READ, S_DECODE, S_HOLD, S_FINISH} state;

    logic [7:0] dwell_q;
    logic [7:0] hold_cnt;
    cmd_e       cmd;

    // command bits sit at the same place in both views
    assign cmd = rd_data.pt.cmd;

    ////////////////////////////////////////
    // display FSM
    ////////////////////////////////////////

    // rd_addr rests at 0 while idle, so word 0 is ready right after go
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rd_addr  <= '0;
            dwell_q  <= '0;
            hold_cnt <= '0;
            xch      <= '0;
            ych      <= '0;
            beam_on  <= 1'b0;
            dac_load <= 1'b0;
            halt     <= 1'b0;
        end else begin
            dac_load <= 1'b0;
            halt     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state <= S_DECODE;
                    end
                end
                // waits out the ram read latency
                S_READ: begin
                    state <= S_DECODE;
                end
                S_DECODE: begin
                    rd_addr <= rd_addr + 1'b1;
                    case (cmd)
                        CMD_DWELL: begin
                            dwell_q <= rd_data.ctl.dwell;
                            state   <= S_READ;
                        end
                        CMD_END: begin
                            // two quiet cycles before halt
                            hold_cnt <= 8'd1;
                            state    <= S_FINISH;
                        end
                        default: begin
                            xch      <= rd_data.pt.x;
                            ych      <= rd_data.pt.y;
                            beam_on  <= (cmd == CMD_DRAW);
                            dac_load <= 1'b1;
                            // decode and read already take two of the dwell cycles
                            hold_cnt <= dwell_q - 8'd2;
                            if (dwell_q > 8'd2) begin
                                state <= S_HOLD;
                            end else begin
                                state <= S_READ;
                            end
                        end
                    endcase
                end
                S_HOLD: begin
                    hold_cnt <= hold_cnt - 1'b1;
                    if (hold_cnt <= 8'd1) begin
                        state <= S_READ;
                    end
                end
                S_FINISH: begin
                    beam_on <= 1'b0;
                    rd_addr <= '0;
                    if (hold_cnt == 8'd0) begin
                        halt  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // end of frame never coincides with a point strobe
    halt_vs_load_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(halt && dac_load));

    // builder must wait for halt before the next go
    go_when_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        go |-> (state == S_IDLE));

endmodule

`default_nettype wire

// ==== frame_builder.sv ====
// frame builder FSM: copies sprites from rom to frame ram with position offsets, go/halt
`default_nettype none

module frame_builder import vector_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               halt,
    input  logic [COORD_W-1:0] cursor_x,
    input  logic [COORD_W-1:0] cursor_y,
    input  logic [COORD_W-1:0] enemy_x,
    input  logic [COORD_W-1:0] enemy_y,
    input  logic               enemy_en,
    input  display_word_u      rom_data,
    output logic [ADDR_W-1:0]  rom_addr,
    output logic               wr_en,
    output logic [ADDR_W-1:0]  wr_addr,
    output display_word_u      wr_data,
    output logic               go
);

    enum logic [2:0] {S_CAPTURE, S_CURSOR, S_ENEMY, S_END, S_GO, S_WAIT} state;

    // positions frozen for the whole build
    logic [COORD_W-1:0] cur_x_q;
    logic [COORD_W-1:0] cur_y_q;
    logic [COORD_W-1:0] enm_x_q;
    logic [COORD_W-1:0] enm_y_q;
    logic               enm_en_q;

    logic               rom_valid;
    logic [ADDR_W-1:0]  wr_ptr;
    logic               fetching;
    logic               shape_end;
    logic               take_word;
    logic [COORD_W-1:0] off_x;
    logic [COORD_W-1:0] off_y;
    display_word_u      wr_next;

    ////////////////////////////////////////
    // rom pipeline decode
    ////////////////////////////////////////

    assign fetching  = (state == S_CURSOR) || (state == S_ENEMY);
    // rom_valid marks data for the address of the previous cycle
    assign shape_end = fetching && rom_valid && (rom_data.pt.cmd == CMD_END);
    assign take_word = fetching && rom_valid && (rom_data.pt.cmd != CMD_END);

    assign off_x = (state == S_ENEMY) ? enm_x_q : cur_x_q;
    assign off_y = (state == S_ENEMY) ? enm_y_q : cur_y_q;

    always_comb begin
        wr_next = rom_data;
        if (state == S_END) begin
            wr_next         = '0;
            wr_next.ctl.cmd = CMD_END;
        end else if (rom_data.pt.cmd == CMD_MOVE || rom_data.pt.cmd == CMD_DRAW) begin
            // screen wraps modulo 256
            wr_next.pt.x = rom_data.pt.x + off_x;
            wr_next.pt.y = rom_data.pt.y + off_y;
        end
    end

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_CAPTURE;
            rom_addr  <= CURSOR_BASE;
            rom_valid <= 1'b0;
            wr_ptr    <= '0;
            wr_en     <= 1'b0;
            go        <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            go    <= 1'b0;
            case (state)
                S_CAPTURE: begin
                    rom_addr  <= CURSOR_BASE;
                    rom_valid <= 1'b0;
                    wr_ptr    <= '0;
                    state     <= S_CURSOR;
                end
                S_CURSOR, S_ENEMY: begin
                    if (shape_end) begin
                        rom_valid <= 1'b0;
                        if (state == S_CURSOR && enm_en_q) begin
                            rom_addr <= ENEMY_BASE;
                            state    <= S_ENEMY;
                        end else begin
                            state <= S_END;
                        end
                    end else begin
                        rom_addr  <= rom_addr + 1'b1;
                        rom_valid <= 1'b1;
                        if (take_word) begin
                            wr_en  <= 1'b1;
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                    end
                end
                S_END: begin
                    // frame terminator
                    wr_en  <= 1'b1;
                    wr_ptr <= wr_ptr + 1'b1;
                    state  <= S_GO;
                end
                S_GO: begin
                    go    <= 1'b1;
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (halt) begin
                        state <= S_CAPTURE;
                    end
                end
                default: state <= S_CAPTURE;
            endcase
        end
    end

    // captured positions and write payload
    always_ff @(posedge clk) begin
        if (state == S_CAPTURE) begin
            cur_x_q  <= cursor_x;
            cur_y_q  <= cursor_y;
            enm_x_q  <= enemy_x;
            enm_y_q  <= enemy_y;
            enm_en_q <= enemy_en;
        end
        if (take_word || state == S_END) begin
            wr_addr <= wr_ptr;
            wr_data <= wr_next;
        end
    end

    // ram is owned by the display while it draws
    wait_no_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_WAIT) |-> !wr_en);

    wr_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_addr < RAM_DEPTH));

endmodule

`default_nettype wire

// ==== frame_ram.sv ====
// frame ram, one write port and one registered read port
`default_nettype none

module frame_ram import vector_pkg::*; (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  display_word_u     wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output display_word_u     rd_data
);

    // one frame of display words
    logic [WORD_W-1:0] mem [RAM_DEPTH];

    ////////////////////////////////////////
    // write port, builder side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[$clog2(RAM_DEPTH)-1:0]] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // read port, display side
    ////////////////////////////////////////

    // one cycle latency, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[$clog2(RAM_DEPTH)-1:0]];
    end

endmodule

`default_nettype wire

// ==== shape_rom.sv ====
// sprite table rom with cursor and enemy shapes, registered read
`default_nettype none

module shape_rom import vector_pkg::*; (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    output display_word_u     data
);

    // point word relative to the sprite origin
    function automatic display_word_u point_word(
        input cmd_e               cmd,
        input logic [COORD_W-1:0] x,
        input logic [COORD_W-1:0] y
    );
        display_word_u w;
        w.pt.cmd = cmd;
        w.pt.x   = x;
        w.pt.y   = y;
        return w;
    endfunction

    // control word, dwell or end
    function automatic display_word_u ctrl_word(
        input cmd_e       cmd,
        input logic [7:0] dwell
    );
        display_word_u w;
        w.ctl.cmd   = cmd;
        w.ctl.dwell = dwell;
        w.ctl.rsvd  = '0;
        return w;
    endfunction

    ////////////////////////////////////////
    // sprite table
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (addr)
            // cursor: a small cross
            CURSOR_BASE + 10'd0: data <= ctrl_word(CMD_DWELL, 8'd3);
            CURSOR_BASE + 10'd1: data <= point_word(CMD_MOVE, 8'd0, 8'd4);
            CURSOR_BASE + 10'd2: data <= point_word(CMD_DRAW, 8'd8, 8'd4);
            CURSOR_BASE + 10'd3: data <= point_word(CMD_MOVE, 8'd4, 8'd0);
            CURSOR_BASE + 10'd4: data <= point_word(CMD_DRAW, 8'd4, 8'd8);
            CURSOR_BASE + 10'd5: data <= ctrl_word(CMD_END, 8'd0);
            // enemy: closed square, slower beam
            ENEMY_BASE + 10'd0:  data <= ctrl_word(CMD_DWELL, 8'd5);
            ENEMY_BASE + 10'd1:  data <= point_word(CMD_MOVE, 8'd0, 8'd0);
            ENEMY_BASE + 10'd2:  data <= point_word(CMD_DRAW, 8'd12, 8'd0);
            ENEMY_BASE + 10'd3:  data <= point_word(CMD_DRAW, 8'd12, 8'd12);
            ENEMY_BASE + 10'd4:  data <= point_word(CMD_DRAW, 8'd0, 8'd12);
            ENEMY_BASE + 10'd5:  data <= point_word(CMD_DRAW, 8'd0, 8'd0);
            ENEMY_BASE + 10'd6:  data <= ctrl_word(CMD_END, 8'd0);
            // empty space reads as end of shape
            default:             data <= ctrl_word(CMD_END, 8'd0);
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_vector_top.sv ====
// testbench for vector_top: clock, reset, point collector, reference model, directed tests
`default_nettype none

module tb_vector_top import vector_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 40 * 80;
    localparam logic [31:0] SEED = 32'hfeeae64f;

    logic               clk;
    logic               rst_n;
    logic [COORD_W-1:0] cursor_x;
    logic [COORD_W-1:0] cursor_y;
    logic [COORD_W-1:0] enemy_x;
    logic [COORD_W-1:0] enemy_y;
    logic               enemy_en;
    logic [COORD_W-1:0] xch;
    logic [COORD_W-1:0] ych;
    logic               beam_on;
    logic               dac_load;
    logic               go_flag;
    logic               halt_flag;

    // collected points and pulse bookkeeping
    int                 cycle_cnt;
    int                 go_count;
    int                 halt_count;
    int                 go_cycle;
    int                 halt_cycle;
    int                 frames_done;
    bit                 drawing;
    logic [COORD_W-1:0] got_x [$];
    logic [COORD_W-1:0] got_y [$];
    logic               got_b [$];
    int                 got_t [$];

    // reference model output
    logic [COORD_W-1:0] exp_x [$];
    logic [COORD_W-1:0] exp_y [$];
    logic               exp_b [$];
    int                 exp_t [$];
    int                 model_t;
    int                 model_dwell;
    int                 exp_halt;

    // sprite table, origin-relative, cursor at 0 and enemy at 6
    cmd_e rom_cmd [13] = '{CMD_DWELL, CMD_MOVE, CMD_DRAW, CMD_MOVE, CMD_DRAW, CMD_END,
                           CMD_DWELL, CMD_MOVE, CMD_DRAW, CMD_DRAW, CMD_DRAW, CMD_DRAW,
                           CMD_END};
    int   rom_a   [13] = '{3, 0, 8, 4, 4, 0, 5, 0, 12, 12, 0, 0, 0};
    int   rom_b   [13] = '{0, 4, 4, 0, 8, 0, 0, 0, 0, 12, 12, 0, 0};

    vector_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_point(input string what, input logic [COORD_W-1:0] ex, ey,
                               input logic eb, input logic [COORD_W-1:0] gx, gy,
                               input logic gb);
        if (gx !== ex || gy !== ey || gb !== eb) begin
            abort_run($sformatf("Error at time %0t: %s expected (%0d,%0d,%b), got (%0d,%0d,%b)",
                                $time, what, ex, ey, eb, gx, gy, gb));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int got);
        if (got != exp) begin
            abort_run($sformatf("Error at time %0t: %s expected %0d, got %0d",
                                $time, what, exp, got));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("Error at time %0t: %s expected %b, got %b",
                                $time, what, exp, got));
        end
    endtask

    ////////////////////////////////////////
    // collector and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: the tests did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end else if (go_flag === 1'b1 && drawing) begin
            abort_run("go arrived while the previous frame was still being drawn");
        end else if ((halt_flag === 1'b1 || dac_load === 1'b1) && !drawing) begin
            abort_run("halt or a point strobe arrived outside a frame");
        end else begin
            if (go_flag === 1'b1) begin
                drawing  = 1'b1;
                go_count = go_count + 1;
                go_cycle = cycle_cnt;
                got_x.delete();
                got_y.delete();
                got_b.delete();
                got_t.delete();
            end
            if (dac_load === 1'b1) begin
                got_x.push_back(xch);
                got_y.push_back(ych);
                got_b.push_back(beam_on);
                got_t.push_back(cycle_cnt);
            end
            if (halt_flag === 1'b1) begin
                drawing    = 1'b0;
                halt_count = halt_count + 1;
                halt_cycle = cycle_cnt;
            end
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // times count from the go pulse
    task automatic add_sprite(input int base, input logic [COORD_W-1:0] ox, oy);
        int addr;
        int px;
        int py;
        addr = base;
        while (rom_cmd[addr] != CMD_END) begin
            if (rom_cmd[addr] == CMD_DWELL) begin
                model_dwell = rom_a[addr];
                model_t     = model_t + 2;
            end else begin
                px = (rom_a[addr] + int'(ox)) % 256;
                py = (rom_b[addr] + int'(oy)) % 256;
                exp_x.push_back(px[COORD_W-1:0]);
                exp_y.push_back(py[COORD_W-1:0]);
                exp_b.push_back(rom_cmd[addr] == CMD_DRAW);
                exp_t.push_back(model_t);
                model_t = model_t + model_dwell;
            end
            addr = addr + 1;
        end
    endtask

    task automatic build_expected(input logic [COORD_W-1:0] cx, cy, ex, ey, input logic en);
        exp_x.delete();
        exp_y.delete();
        exp_b.delete();
        exp_t.delete();
        // address issue plus read latency
        model_t     = 2;
        model_dwell = 0;
        add_sprite(int'(CURSOR_BASE), cx, cy);
        if (en) begin
            add_sprite(int'(ENEMY_BASE), ex, ey);
        end
        exp_halt = model_t + 2;
    endtask

    ////////////////////////////////////////
    // frame helpers
    ////////////////////////////////////////

    task automatic drive_positions(input logic [COORD_W-1:0] cx, cy, ex, ey, input logic en);
        cursor_x = cx;
        cursor_y = cy;
        enemy_x  = ex;
        enemy_y  = ey;
        enemy_en = en;
    endtask

    task automatic wait_pulse(input bit for_halt);
        int seen;
        seen = for_halt ? halt_count : go_count;
        while ((for_halt ? halt_count : go_count) == seen) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_frame(input logic [COORD_W-1:0] cx, cy, ex, ey, input logic en);
        build_expected(cx, cy, ex, ey, en);
        check_count("points in frame", exp_x.size(), got_x.size());
        foreach (exp_x[i]) begin
            check_point($sformatf("point %0d", i), exp_x[i], exp_y[i], exp_b[i],
                        got_x[i], got_y[i], got_b[i]);
            check_count($sformatf("cycles from go to point %0d", i), exp_t[i],
                        got_t[i] - go_cycle);
        end
        check_count("cycles from go to halt", exp_halt, halt_cycle - go_cycle);
        frames_done = frames_done + 1;
        check_count("go pulses", frames_done, go_count);
        check_count("halt pulses", frames_done, halt_count);
    endtask

    // called before the builder captures, i.e. in reset or right after halt
    task automatic run_frame(input logic [COORD_W-1:0] cx, cy, ex, ey, input logic en);
        drive_positions(cx, cy, ex, ey, en);
        wait_pulse(1'b0);
        wait_pulse(1'b1);
        check_frame(cx, cy, ex, ey, en);
    endtask

    task automatic check_gaps(input int first, input int last, input int gap);
        for (int i = first; i <= last; i++) begin
            check_count($sformatf("dac_load spacing before point %0d", i), gap,
                        got_t[i] - got_t[i-1]);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #2;
            check_point("outputs around reset", 8'd0, 8'd0, 1'b0, xch, ych, beam_on);
            check_flag("go_flag around reset", 1'b0, go_flag);
            check_flag("halt_flag around reset", 1'b0, halt_flag);
            check_flag("dac_load around reset", 1'b0, dac_load);
            if (i == 3) begin
                rst_n = 1'b1;
            end
        end
    endtask

    task automatic test_cursor_only();
        // same positions as applied during reset
        run_frame(8'd100, 8'd50, 8'd0, 8'd0, 1'b0);
        check_count("cursor-only points", 4, got_x.size());
        check_count("first dac_load after go", 4, got_t[0] - go_cycle);
        check_gaps(1, 3, 3);
    endtask

    task automatic test_cursor_enemy();
        run_frame(8'd30, 8'd40, 8'd120, 8'd90, 1'b1);
        check_count("cursor plus enemy points", 9, got_x.size());
        check_gaps(4, 8, 5);
    endtask

    task automatic test_wrap();
        run_frame(8'd250, 8'd253, 8'd248, 8'd250, 1'b1);
        check_point("wrapped cursor draw", 8'd2, 8'd1, 1'b1, got_x[1], got_y[1], got_b[1]);
        check_point("wrapped enemy corner", 8'd4, 8'd6, 1'b1, got_x[6], got_y[6], got_b[6]);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] r_en;
        repeat (6) begin
            r    = $urandom;
            r_en = $urandom;
            run_frame(r[7:0], r[15:8], r[23:16], r[31:24], r_en[0]);
        end
    endtask

    task automatic test_midframe();
        // taken by the capture cycle right after halt
        drive_positions(8'd60, 8'd70, 8'd10, 8'd20, 1'b1);
        @(posedge clk);
        #2;
        // builder is copying sprites now
        drive_positions(8'd15, 8'd230, 8'd140, 8'd35, 1'b0);
        wait_pulse(1'b0);
        while (got_x.size() < 2) begin
            @(posedge clk);
            #2;
        end
        drive_positions(8'd200, 8'd5, 8'd90, 8'd180, 1'b0);
        wait_pulse(1'b1);
        check_frame(8'd60, 8'd70, 8'd10, 8'd20, 1'b1);
        run_frame(8'd200, 8'd5, 8'd90, 8'd180, 1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        drive_positions(8'd100, 8'd50, 8'd0, 8'd0, 1'b0);
        test_reset();
        test_cursor_only();
        test_cursor_enemy();
        test_wrap();
        test_random();
        test_midframe();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vector_pkg.sv ====
// widths, command codes, rom sprite bases, frame ram depth and the display word union
`default_nettype none

package vector_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    // one screen coordinate on the dac
    localparam int COORD_W = 8;

    // command + two coordinates
    localparam int WORD_W = 18;

    // shared by shape rom and frame ram
    localparam int ADDR_W = 10;

    // one frame, no double buffering
    localparam int RAM_DEPTH = 64;

    ////////////////////////////////////////
    // display word
    ////////////////////////////////////////

    // top two bits of every display word
    typedef enum logic [1:0] {
        CMD_MOVE  = 2'd0,
        CMD_DRAW  = 2'd1,
        CMD_DWELL = 2'd2,
        CMD_END   = 2'd3
    } cmd_e;

    // sprite start addresses in the shape rom
    localparam logic [ADDR_W-1:0] CURSOR_BASE = 10'd0;
    localparam logic [ADDR_W-1:0] ENEMY_BASE  = 10'd6;

    // point view for move/draw, control view for dwell and end
    typedef union packed {
        struct packed {
            cmd_e               cmd;
            logic [COORD_W-1:0] x;
            logic [COORD_W-1:0] y;
        } pt;
        struct packed {
            cmd_e       cmd;
            logic [7:0] dwell;
            logic [7:0] rsvd;
        } ctl;
    } display_word_u;

endpackage

`default_nettype wire

// ==== vector_top.f ====
vector_pkg.sv
shape_rom.sv
frame_builder.sv
frame_ram.sv
beam_sequencer.sv
vector_top.sv
tb_vector_top.sv

// ==== vector_top.sv ====
// top level: shape rom, frame builder, frame ram and beam sequencer
`default_nettype none

module vector_top import vector_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [COORD_W-1:0] cursor_x,
    input  logic [COORD_W-1:0] cursor_y,
    input  logic [COORD_W-1:0] enemy_x,
    input  logic [COORD_W-1:0] enemy_y,
    input  logic               enemy_en,
    output logic [COORD_W-1:0] xch,
    output logic [COORD_W-1:0] ych,
    output logic               beam_on,
    output logic               dac_load,
    output logic               go_flag,
    output logic               halt_flag
);

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////

    logic [ADDR_W-1:0] rom_addr;
    display_word_u     rom_data;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    display_word_u     wr_data;
    logic [ADDR_W-1:0] rd_addr;
    display_word_u     rd_data;

    // frame handshake between builder and display
    logic go;
    logic halt;

    assign go_flag   = go;
    assign halt_flag = halt;

    ////////////////////////////////////////
    // submodules
    ////////////////////////////////////////

    shape_rom u_shape_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    frame_builder u_frame_builder (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt     (halt),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y),
        .enemy_x  (enemy_x),
        .enemy_y  (enemy_y),
        .enemy_en (enemy_en),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .go       (go)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    beam_sequencer u_beam_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .go       (go),
        .rd_data  (rd_data),
        .rd_addr  (rd_addr),
        .xch      (xch),
        .ych      (ych),
        .beam_on  (beam_on),
        .dac_load (dac_load),
        .halt     (halt)
    );

endmodule

`default_nettype wire
